// ==== source/mgmt_regs_pkg.sv ====
/*
 * Register map of the management block.
 * Only region 0 (address bits 11:10 == 0) is decoded; bits above 11 are ignored.
 */
`default_nettype none

package mgmt_regs_pkg;

    localparam int ADDR_WIDTH       = 16;
    localparam int DATA_WIDTH       = 32;
    localparam int REG_OFFSET_WIDTH = 10;
    localparam int STATUS_WIDTH     = 16;

    // Offsets inside region 0
    localparam logic [REG_OFFSET_WIDTH-1:0] REG_STATUS     = 10'h000;
    localparam logic [REG_OFFSET_WIDTH-1:0] REG_INT_ENABLE = 10'h008;
    localparam logic [REG_OFFSET_WIDTH-1:0] REG_INT_STATUS = 10'h00c;
    localparam logic [REG_OFFSET_WIDTH-1:0] REG_CONTROL    = 10'h020;
    localparam logic [REG_OFFSET_WIDTH-1:0] REG_MDIO_CMD   = 10'h024;
    localparam logic [REG_OFFSET_WIDTH-1:0] REG_MDIO_DATA  = 10'h028;
    localparam logic [REG_OFFSET_WIDTH-1:0] REG_CAPS       = 10'h02c;

    // Status vector sits in the low bits of interrupt status
    localparam int INT_MDIO_IDLE_BIT = 16;
    localparam int INT_PHY_BIT       = 17;

    localparam int CTRL_PHY_RESET_BIT = 2;

    // Bit 8 marks the MDIO master as present
    localparam logic [DATA_WIDTH-1:0] CAPS_VALUE = 32'h0000_0100;

endpackage

`default_nettype wire

// ==== source/mdio_pkg.sv ====
/*
 * MDIO (clause 22) transaction layout.
 * One transaction is a preamble of ones followed by a 32-bit frame, MSB first.
 */
`default_nettype none

package mdio_pkg;

    localparam int MDIO_BITS          = 64;
    localparam int MDIO_PREAMBLE_BITS = 32;

    // Read frames release the line from here on
    localparam int MDIO_TURNAROUND_START = 46;

    // High bit of the opcode field, set for reads
    localparam int MDIO_READ_OP_BIT = 29;

    localparam int MDIO_DATA_WIDTH = 16;

endpackage

`default_nettype wire

// ==== source/axil_port.sv ====
/*
 * AXI4-Lite slave front end. One outstanding read and one outstanding write.
 * AW and W may arrive in any order. Responses are always OKAY.
 */
`timescale 1ns/1ps
`default_nettype none

module axil_port (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [mgmt_regs_pkg::ADDR_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                                 s_axi_awvalid_i,
    output logic                                 s_axi_awready_o,
    input  logic [mgmt_regs_pkg::DATA_WIDTH-1:0] s_axi_wdata_i,
    input  logic                                 s_axi_wvalid_i,
    output logic                                 s_axi_wready_o,
    output logic [1:0]                           s_axi_bresp_o,
    output logic                                 s_axi_bvalid_o,
    input  logic                                 s_axi_bready_i,
    input  logic [mgmt_regs_pkg::ADDR_WIDTH-1:0] s_axi_araddr_i,
    input  logic                                 s_axi_arvalid_i,
    output logic                                 s_axi_arready_o,
    output logic [mgmt_regs_pkg::DATA_WIDTH-1:0] s_axi_rdata_o,
    output logic [1:0]                           s_axi_rresp_o,
    output logic                                 s_axi_rvalid_o,
    input  logic                                 s_axi_rready_i,
    output logic                                 reg_wr_o,
    output logic [mgmt_regs_pkg::ADDR_WIDTH-1:0] reg_waddr_o,
    output logic [mgmt_regs_pkg::DATA_WIDTH-1:0] reg_wdata_o,
    output logic                                 reg_rd_o,
    output logic [mgmt_regs_pkg::ADDR_WIDTH-1:0] reg_raddr_o,
    input  logic [mgmt_regs_pkg::DATA_WIDTH-1:0] reg_rdata_i
);
    import mgmt_regs_pkg::*;

    logic                  aw_pend;
    logic                  w_pend;
    logic                  rd_pend;
    logic [ADDR_WIDTH-1:0] waddr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [ADDR_WIDTH-1:0] raddr;

    // Each channel closes until its response has been taken
    assign s_axi_awready_o = !aw_pend && !s_axi_bvalid_o;
    assign s_axi_wready_o  = !w_pend && !s_axi_bvalid_o;
    assign s_axi_arready_o = !rd_pend && !s_axi_rvalid_o;

    assign s_axi_bresp_o = 2'b00;
    assign s_axi_rresp_o = 2'b00;

    assign reg_wr_o    = aw_pend && w_pend && !s_axi_bvalid_o;
    assign reg_waddr_o = waddr;
    assign reg_wdata_o = wdata;
    assign reg_rd_o    = rd_pend && !s_axi_rvalid_o;
    assign reg_raddr_o = raddr;

    always_ff @(posedge clock) begin
        if (s_axi_awready_o && s_axi_awvalid_i) begin
            waddr <= s_axi_awaddr_i;
        end
        if (s_axi_wready_o && s_axi_wvalid_i) begin
            wdata <= s_axi_wdata_i;
        end
        if (s_axi_arready_o && s_axi_arvalid_i) begin
            raddr <= s_axi_araddr_i;
        end
        if (reg_rd_o) begin
            s_axi_rdata_o <= reg_rdata_i;
        end
    end

    // Write channel
    always_ff @(posedge clock) begin
        if (reset) begin
            aw_pend        <= 1'b0;
            w_pend         <= 1'b0;
            s_axi_bvalid_o <= 1'b0;
        end else begin
            if (s_axi_awready_o && s_axi_awvalid_i) begin
                aw_pend <= 1'b1;
            end
            if (s_axi_wready_o && s_axi_wvalid_i) begin
                w_pend <= 1'b1;
            end
            if (s_axi_bvalid_o && s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end else if (reg_wr_o) begin
                s_axi_bvalid_o <= 1'b1;
                aw_pend        <= 1'b0;
                w_pend         <= 1'b0;
            end
        end
    end

    // Read channel
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_pend        <= 1'b0;
            s_axi_rvalid_o <= 1'b0;
        end else begin
            if (s_axi_arready_o && s_axi_arvalid_i) begin
                rd_pend <= 1'b1;
            end
            if (s_axi_rvalid_o && s_axi_rready_i) begin
                s_axi_rvalid_o <= 1'b0;
            end else if (reg_rd_o) begin
                s_axi_rvalid_o <= 1'b1;
                rd_pend        <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mgmt_regs.sv ====
/*
 * Register file, interrupt logic and MDIO start/done handshake.
 * A write to the MDIO command register is dropped while a frame is in flight.
 * phy_int_i may be asynchronous; it passes a three-stage synchronizer.
 */
`timescale 1ns/1ps
`default_nettype none

module mgmt_regs (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   reg_wr_i,
    input  logic [mgmt_regs_pkg::ADDR_WIDTH-1:0]   reg_waddr_i,
    input  logic [mgmt_regs_pkg::DATA_WIDTH-1:0]   reg_wdata_i,
    input  logic                                   reg_rd_i,
    input  logic [mgmt_regs_pkg::ADDR_WIDTH-1:0]   reg_raddr_i,
    output logic [mgmt_regs_pkg::DATA_WIDTH-1:0]   reg_rdata_o,
    input  logic [mgmt_regs_pkg::STATUS_WIDTH-1:0] status_vector_i,
    output logic                                   interrupt_o,
    output logic                                   phy_reset_o,
    input  logic                                   phy_int_i,
    output logic                                   mdio_start_o,
    output logic [mgmt_regs_pkg::DATA_WIDTH-1:0]   mdio_cmd_o,
    input  logic                                   mdio_done_i,
    input  logic [mgmt_regs_pkg::DATA_WIDTH-1:0]   mdio_rdata_i
);
    import mgmt_regs_pkg::*;

    logic [DATA_WIDTH-1:0]       int_enable;
    logic [DATA_WIDTH-1:0]       int_status;
    logic [DATA_WIDTH-1:0]       control;
    logic [2:0]                  phy_int_sync;
    logic                        mdio_idle;
    logic                        wr_hit;
    logic                        rd_hit;
    logic [REG_OFFSET_WIDTH-1:0] woff;
    logic [REG_OFFSET_WIDTH-1:0] roff;

    // Only region 0 is mapped
    assign wr_hit = reg_wr_i && reg_waddr_i[REG_OFFSET_WIDTH +: 2] == 2'b00;
    assign rd_hit = reg_rd_i && reg_raddr_i[REG_OFFSET_WIDTH +: 2] == 2'b00;
    assign woff   = reg_waddr_i[REG_OFFSET_WIDTH-1:0];
    assign roff   = reg_raddr_i[REG_OFFSET_WIDTH-1:0];

    assign mdio_idle = !(mdio_start_o || mdio_done_i);

    always_comb begin
        int_status = '0;
        int_status[STATUS_WIDTH-1:0] = status_vector_i;
        int_status[INT_MDIO_IDLE_BIT] = mdio_idle;
        int_status[INT_PHY_BIT] = phy_int_sync[2];
    end

    assign interrupt_o = |(int_enable & int_status);
    assign phy_reset_o = !control[CTRL_PHY_RESET_BIT];

    always_ff @(posedge clock) begin
        if (reset) begin
            phy_int_sync <= '0;
        end else begin
            phy_int_sync <= {phy_int_sync[1:0], phy_int_i};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            int_enable   <= '0;
            control      <= '0;
            mdio_cmd_o   <= '0;
            mdio_start_o <= 1'b0;
        end else begin
            // Master drops done once start is released
            if (mdio_start_o && mdio_done_i) begin
                mdio_start_o <= 1'b0;
            end
            if (wr_hit) begin
                case (woff)
                    REG_INT_ENABLE: int_enable <= reg_wdata_i;
                    REG_CONTROL:    control <= reg_wdata_i;
                    REG_MDIO_CMD: begin
                        if (mdio_idle) begin
                            mdio_cmd_o   <= reg_wdata_i;
                            mdio_start_o <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        reg_rdata_o = '0;
        if (rd_hit) begin
            case (roff)
                REG_STATUS:     reg_rdata_o = DATA_WIDTH'(status_vector_i);
                REG_INT_ENABLE: reg_rdata_o = int_enable;
                REG_INT_STATUS: reg_rdata_o = int_status;
                REG_CONTROL:    reg_rdata_o = control;
                REG_MDIO_CMD:   reg_rdata_o = mdio_cmd_o;
                REG_MDIO_DATA:  reg_rdata_o = mdio_rdata_i;
                REG_CAPS:       reg_rdata_o = CAPS_VALUE;
                default:        reg_rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/mdio_master.sv ====
/*
 * MDIO management master. MDC runs at clock / (2 * MDC_HALF_PERIOD).
 * cmd_i must stay stable while start_i is high. mdio_i is sampled as MDC rises,
 * so the PHY is expected to drive during the low half.
 */
`timescale 1ns/1ps
`default_nettype none

module mdio_master #(
    parameter int MDC_HALF_PERIOD = 25
) (
    input  logic                                                        clock,
    input  logic                                                        reset,
    input  logic                                                        start_i,
    input  logic [mdio_pkg::MDIO_BITS-mdio_pkg::MDIO_PREAMBLE_BITS-1:0] cmd_i,
    output logic                                                        done_o,
    output logic [mdio_pkg::MDIO_BITS-mdio_pkg::MDIO_PREAMBLE_BITS-1:0] rdata_o,
    output logic                                                        mdc_o,
    output logic                                                        mdio_o,
    output logic                                                        mdio_oe_o,
    input  logic                                                        mdio_i
);
    import mdio_pkg::*;

    localparam int FRAME_BITS = MDIO_BITS - MDIO_PREAMBLE_BITS;
    localparam int BIT_W      = $clog2(MDIO_BITS);
    localparam int IDX_W      = $clog2(FRAME_BITS);
    localparam int DIV_W      = $clog2(MDC_HALF_PERIOD + 1);
    localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(MDC_HALF_PERIOD - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [BIT_W-1:0] frame_off;
    logic [IDX_W-1:0] frame_idx;
    logic             busy;
    logic             in_frame;
    logic             is_read;
    logic             half_end;
    logic             sample;

    assign busy      = start_i && !done_o;
    assign in_frame  = bit_cnt >= BIT_W'(MDIO_PREAMBLE_BITS);
    assign frame_off = bit_cnt - BIT_W'(MDIO_PREAMBLE_BITS);
    // Frame goes out MSB first
    assign frame_idx = IDX_W'(FRAME_BITS - 1) - frame_off[IDX_W-1:0];
    assign is_read   = cmd_i[MDIO_READ_OP_BIT];
    assign half_end  = busy && div_cnt == '0;
    assign sample    = half_end && !mdc_o && in_frame;

    // Preamble and idle line are ones; a read hands the line over at turnaround
    assign mdio_oe_o = busy && !(is_read && bit_cnt >= BIT_W'(MDIO_TURNAROUND_START));
    assign mdio_o    = !busy || !in_frame || cmd_i[frame_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            mdc_o   <= 1'b0;
            done_o  <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (!start_i) begin
            mdc_o   <= 1'b0;
            done_o  <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= DIV_LOAD;
        end else if (!done_o) begin
            if (div_cnt != '0) begin
                div_cnt <= div_cnt - 1'b1;
            end else begin
                div_cnt <= DIV_LOAD;
                mdc_o   <= !mdc_o;
                // End of the high half closes the bit time
                if (mdc_o) begin
                    if (bit_cnt == BIT_W'(MDIO_BITS - 1)) begin
                        done_o <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Whole frame is captured and the PHY data ends up in the low bits
    always_ff @(posedge clock) begin
        if (sample) begin
            rdata_o[frame_idx] <= mdio_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/mac_mgmt_top.sv ====
/*
 * Management side of the Ethernet controller: AXI4-Lite registers,
 * interrupt and MDIO master. The MDIO pin is split into o/oe/i;
 * the tristate buffer lives outside this block.
 */
`timescale 1ns/1ps
`default_nettype none

module mac_mgmt_top #(
    parameter int MDC_HALF_PERIOD = 25
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [mgmt_regs_pkg::ADDR_WIDTH-1:0]   s_axi_awaddr_i,
    input  logic                                   s_axi_awvalid_i,
    output logic                                   s_axi_awready_o,
    input  logic [mgmt_regs_pkg::DATA_WIDTH-1:0]   s_axi_wdata_i,
    input  logic                                   s_axi_wvalid_i,
    output logic                                   s_axi_wready_o,
    output logic [1:0]                             s_axi_bresp_o,
    output logic                                   s_axi_bvalid_o,
    input  logic                                   s_axi_bready_i,
    input  logic [mgmt_regs_pkg::ADDR_WIDTH-1:0]   s_axi_araddr_i,
    input  logic                                   s_axi_arvalid_i,
    output logic                                   s_axi_arready_o,
    output logic [mgmt_regs_pkg::DATA_WIDTH-1:0]   s_axi_rdata_o,
    output logic [1:0]                             s_axi_rresp_o,
    output logic                                   s_axi_rvalid_o,
    input  logic                                   s_axi_rready_i,
    input  logic [mgmt_regs_pkg::STATUS_WIDTH-1:0] status_vector_i,
    output logic                                   interrupt_o,
    output logic                                   mdc_o,
    output logic                                   mdio_o,
    output logic                                   mdio_oe_o,
    input  logic                                   mdio_i,
    output logic                                   phy_reset_o,
    input  logic                                   phy_int_i
);
    import mgmt_regs_pkg::*;

    logic                  reg_wr;
    logic [ADDR_WIDTH-1:0] reg_waddr;
    logic [DATA_WIDTH-1:0] reg_wdata;
    logic                  reg_rd;
    logic [ADDR_WIDTH-1:0] reg_raddr;
    logic [DATA_WIDTH-1:0] reg_rdata;
    logic                  mdio_start;
    logic                  mdio_done;
    logic [DATA_WIDTH-1:0] mdio_cmd;
    logic [DATA_WIDTH-1:0] mdio_rdata;

    axil_port i_axil_port (
        .clock           (clock),
        .reset           (reset),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .reg_wr_o        (reg_wr),
        .reg_waddr_o     (reg_waddr),
        .reg_wdata_o     (reg_wdata),
        .reg_rd_o        (reg_rd),
        .reg_raddr_o     (reg_raddr),
        .reg_rdata_i     (reg_rdata)
    );

    mgmt_regs i_mgmt_regs (
        .clock           (clock),
        .reset           (reset),
        .reg_wr_i        (reg_wr),
        .reg_waddr_i     (reg_waddr),
        .reg_wdata_i     (reg_wdata),
        .reg_rd_i        (reg_rd),
        .reg_raddr_i     (reg_raddr),
        .reg_rdata_o     (reg_rdata),
        .status_vector_i (status_vector_i),
        .interrupt_o     (interrupt_o),
        .phy_reset_o     (phy_reset_o),
        .phy_int_i       (phy_int_i),
        .mdio_start_o    (mdio_start),
        .mdio_cmd_o      (mdio_cmd),
        .mdio_done_i     (mdio_done),
        .mdio_rdata_i    (mdio_rdata)
    );

    mdio_master #(
        .MDC_HALF_PERIOD (MDC_HALF_PERIOD)
    ) i_mdio_master (
        .clock     (clock),
        .reset     (reset),
        .start_i   (mdio_start),
        .cmd_i     (mdio_cmd),
        .done_o    (mdio_done),
        .rdata_o   (mdio_rdata),
        .mdc_o     (mdc_o),
        .mdio_o    (mdio_o),
        .mdio_oe_o (mdio_oe_o),
        .mdio_i    (mdio_i)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_phy_mdio.sv ====
/*
 * Behavioral clause 22 PHY for simulation. Counts 64 MDC rising edges per
 * transaction, so it must see every transaction from the start.
 * Register table starts at phy address XOR register address.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_phy_mdio (
    input  logic mdc_i,
    input  logic mdio_i,
    output logic mdio_o,
    output logic mdio_oe_o
);
    import mdio_pkg::*;

    logic [MDIO_DATA_WIDTH-1:0] regs [0:31][0:31];
    logic [31:0]                frame;
    int                         bit_idx;

    initial begin
        for (int p = 0; p < 32; p++) begin
            for (int r = 0; r < 32; r++) begin
                regs[p][r] = MDIO_DATA_WIDTH'(p ^ r);
            end
        end
        frame     = '0;
        bit_idx   = 0;
        mdio_o    = 1'b1;
        mdio_oe_o = 1'b0;
    end

    // Capture on the rising edge and commit writes after the last bit
    always @(posedge mdc_i) begin
        if (bit_idx >= MDIO_PREAMBLE_BITS) begin
            frame[MDIO_BITS-1-bit_idx] = mdio_i;
        end
        if (bit_idx == MDIO_BITS - 1) begin
            if (!frame[MDIO_READ_OP_BIT]) begin
                regs[frame[27:23]][frame[22:18]] = frame[15:0];
            end
            bit_idx = 0;
        end else begin
            bit_idx = bit_idx + 1;
        end
    end

    // Drive the next bit while MDC is low
    always @(negedge mdc_i) begin
        if (bit_idx > MDIO_TURNAROUND_START && frame[MDIO_READ_OP_BIT]) begin
            mdio_oe_o = 1'b1;
            if (bit_idx == MDIO_TURNAROUND_START + 1) begin
                mdio_o = 1'b0;
            end else begin
                mdio_o = regs[frame[27:23]][frame[22:18]][MDIO_BITS-1-bit_idx];
            end
        end else begin
            mdio_oe_o = 1'b0;
            mdio_o    = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/mac_mgmt_sva.sv ====
/*
 * Protocol assertions, bound into mac_mgmt_top.
 */
`timescale 1ns/1ps
`default_nettype none

module mac_mgmt_sva (
    input logic        clock,
    input logic        reset,
    input logic        rvalid_i,
    input logic        rready_i,
    input logic [31:0] rdata_i,
    input logic        bvalid_i,
    input logic        bready_i,
    input logic        mdc_i,
    input logic        mdio_oe_i
);

    // Held responses keep valid and data
    read_held: assert property (@(posedge clock) disable iff (reset)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
        else $error("read response changed while stalled");

    write_held: assert property (@(posedge clock) disable iff (reset)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("write response dropped while stalled");

    oe_after_reset: assert property (@(posedge clock)
        reset |=> !mdio_oe_i)
        else $error("MDIO output enabled after reset");

    // Transaction starts with MDC low
    oe_rise_mdc_low: assert property (@(posedge clock) disable iff (reset)
        $rose(mdio_oe_i) |-> !mdc_i)
        else $error("MDIO output enable rose with MDC high");

endmodule

bind mac_mgmt_top mac_mgmt_sva i_mac_mgmt_sva (
    .clock     (clock),
    .reset     (reset),
    .rvalid_i  (s_axi_rvalid_o),
    .rready_i  (s_axi_rready_i),
    .rdata_i   (s_axi_rdata_o),
    .bvalid_i  (s_axi_bvalid_o),
    .bready_i  (s_axi_bready_i),
    .mdc_i     (mdc_o),
    .mdio_oe_i (mdio_oe_o)
);

`default_nettype wire

// ==== testbench/tb_mac_mgmt.sv ====
/*
 * Random AXI4-Lite traffic against a register model, plus MDIO frames
 * to a behavioral PHY. MDC_HALF_PERIOD is 4, so one bit time is 8 clocks.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mac_mgmt;
    import mgmt_regs_pkg::*;
    import mdio_pkg::*;

    localparam int N_RANDOM_OPS   = 120;
    localparam int N_INT_STEPS    = 16;
    localparam int N_MDIO_PAIRS   = 8;
    localparam int TIMEOUT_CYCLES = 2 * N_MDIO_PAIRS * MDIO_BITS * 8 + 4000;

    logic clock, reset;
    logic [15:0] awaddr, araddr, status_vector;
    logic [31:0] wdata, rdata;
    logic awvalid, wvalid, bready, arvalid, rready, phy_int;
    logic awready, wready, bvalid, arready, rvalid, interrupt, phy_reset;
    logic [1:0] bresp, rresp;
    logic mdc, mdio_out, mdio_oe, mdio_line, phy_drive, phy_oe;

    logic [31:0] m_int_enable, m_control, m_cmd;
    logic [15:0] m_phy [0:31][0:31];
    integer seed;
    int errors, cycles;

    // Master wins when enabled, then the PHY, then the pull-up
    assign mdio_line = mdio_oe ? mdio_out : (phy_oe ? phy_drive : 1'b1);

    mac_mgmt_top #(.MDC_HALF_PERIOD(4)) i_mac_mgmt_top (
        .clock(clock), .reset(reset),
        .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
        .s_axi_wdata_i(wdata), .s_axi_wvalid_i(wvalid), .s_axi_wready_o(wready),
        .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid), .s_axi_bready_i(bready),
        .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
        .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp), .s_axi_rvalid_o(rvalid),
        .s_axi_rready_i(rready), .status_vector_i(status_vector), .interrupt_o(interrupt),
        .mdc_o(mdc), .mdio_o(mdio_out), .mdio_oe_o(mdio_oe), .mdio_i(mdio_line),
        .phy_reset_o(phy_reset), .phy_int_i(phy_int)
    );

    tb_phy_mdio i_tb_phy_mdio (
        .mdc_i(mdc), .mdio_i(mdio_line), .mdio_o(phy_drive), .mdio_oe_o(phy_oe)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake or MDIO frame never finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
        int w_delay;
        bit aw_done, w_done, aw_hs, w_hs, b_done;
        w_delay = $unsigned($random(seed)) % 3;
        aw_done = 0;
        w_done  = 0;
        b_done  = 0;
        @(posedge clock);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= (w_delay == 0);
        while (!(aw_done && w_done)) begin
            @(negedge clock);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge clock);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_done = 1;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_done = 1;
            end else if (!w_done && w_delay > 0) begin
                w_delay--;
                if (w_delay == 0) begin
                    wvalid <= 1'b1;
                end
            end
        end
        while (!b_done) begin
            bready <= 1'($random(seed));
            @(negedge clock);
            if (bvalid && bready) begin
                b_done = 1;
                check_value("bresp", 32'h0, 32'(bresp));
            end
            @(posedge clock);
        end
        bready <= 1'b0;
        @(negedge clock);
        if (bvalid) begin
            errors++;
            $display("Write response repeated after it was accepted");
        end
    endtask

    task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
        bit r_done;
        r_done = 0;
        data   = '0;
        @(posedge clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        do begin
            @(negedge clock);
            r_done = arvalid && arready;
            @(posedge clock);
        end while (!r_done);
        arvalid <= 1'b0;
        r_done = 0;
        while (!r_done) begin
            rready <= 1'($random(seed));
            @(negedge clock);
            if (rvalid && rready) begin
                r_done = 1;
                data   = rdata;
                check_value("rresp", 32'h0, 32'(rresp));
            end
            @(posedge clock);
        end
        rready <= 1'b0;
        @(negedge clock);
        if (rvalid) begin
            errors++;
            $display("Read response repeated after it was accepted");
        end
    endtask

    // Interrupt status as seen with the MDIO master idle
    function automatic logic [31:0] status_word();
        logic [31:0] word;
        word = 32'(status_vector);
        word[INT_MDIO_IDLE_BIT] = 1'b1;
        word[INT_PHY_BIT] = phy_int;
        return word;
    endfunction

    function automatic logic [31:0] expected_read(input logic [15:0] addr);
        if (addr[11:10] != 2'b00) begin
            return '0;
        end
        case (addr[9:0])
            REG_STATUS:     return 32'(status_vector);
            REG_INT_ENABLE: return m_int_enable;
            REG_INT_STATUS: return status_word();
            REG_CONTROL:    return m_control;
            REG_MDIO_CMD:   return m_cmd;
            REG_CAPS:       return 32'h0000_0100;
            default:        return '0;
        endcase
    endfunction

    function automatic logic [15:0] pick_addr(input bit for_write);
        logic [9:0] off;
        logic [1:0] region;
        case ($unsigned($random(seed)) % 8)
            0: off = REG_STATUS;
            1: off = REG_INT_ENABLE;
            2: off = REG_INT_STATUS;
            3: off = REG_CONTROL;
            4: off = REG_CAPS;
            5: off = REG_MDIO_CMD;
            default: off = 10'h030 + 10'(($unsigned($random(seed)) % 244) * 4);
        endcase
        region = ($unsigned($random(seed)) % 4 == 0) ? 2'($random(seed)) : 2'b00;
        if (for_write && region == 2'b00 && off == REG_MDIO_CMD) begin
            off = REG_CONTROL;
        end
        return {4'($random(seed)), region, off};
    endfunction

    task automatic write_and_model(input logic [15:0] addr, input logic [31:0] data);
        axi_write(addr, data);
        if (addr[11:10] == 2'b00 && addr[9:0] == REG_INT_ENABLE) begin
            m_int_enable = data;
        end
        if (addr[11:10] == 2'b00 && addr[9:0] == REG_CONTROL) begin
            m_control = data;
            check_value("phy_reset", 32'(!data[2]), 32'(phy_reset));
        end
    endtask

    task automatic wait_mdio_idle();
        logic [31:0] data;
        data = '0;
        while (!data[INT_MDIO_IDLE_BIT]) begin
            axi_read(16'(REG_INT_STATUS), data);
        end
    endtask

    initial begin
        logic [15:0] addr;
        logic [31:0] data, got;
        logic [4:0] pa, ra;
        clock = 0;
        reset = 1;
        seed = 32'hf462;
        errors = 0;
        cycles = 0;
        awaddr = '0;
        awvalid = 0;
        wdata = '0;
        wvalid = 0;
        bready = 0;
        araddr = '0;
        arvalid = 0;
        rready = 0;
        status_vector = '0;
        phy_int = 0;
        m_int_enable = '0;
        m_control = '0;
        m_cmd = '0;
        for (int p = 0; p < 32; p++) begin
            for (int r = 0; r < 32; r++) begin
                m_phy[p][r] = 16'(p ^ r);
            end
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        // Expect rvalid, bvalid, irq, mdc and oe low and mdio and phy_reset high
        check_value("reset_outputs", 32'b0000011,
                    32'({rvalid, bvalid, interrupt, mdc, mdio_oe, mdio_out, phy_reset}));
        axi_read(16'(REG_CONTROL), got);
        check_value("reset_control", 32'h0, got);
        axi_read(16'(REG_INT_ENABLE), got);
        check_value("reset_int_enable", 32'h0, got);
        axi_read(16'(REG_MDIO_CMD), got);
        check_value("reset_mdio_cmd", 32'h0, got);

        for (int i = 0; i < N_RANDOM_OPS; i++) begin
            @(posedge clock);
            status_vector <= 16'($random(seed));
            if ($random(seed) & 1) begin
                write_and_model(pick_addr(1), $random(seed));
            end else begin
                addr = pick_addr(0);
                axi_read(addr, got);
                check_value("random_read", expected_read(addr), got);
            end
            check_value("interrupt", 32'(|(m_int_enable & status_word())), 32'(interrupt));
        end

        for (int i = 0; i < N_INT_STEPS; i++) begin
            @(posedge clock);
            phy_int <= 1'($random(seed));
            write_and_model(16'(REG_INT_ENABLE), $random(seed) & 32'h0003_00ff);
            axi_read(16'(REG_INT_STATUS), got);
            check_value("int_status", status_word(), got);
            check_value("int_phy", 32'(|(m_int_enable & status_word())), 32'(interrupt));
        end

        for (int i = 0; i < N_MDIO_PAIRS; i++) begin
            pa = 5'($random(seed));
            ra = 5'($random(seed));
            data = {2'b01, 2'b01, pa, ra, 2'b10, 16'($random(seed))};
            axi_write(16'(REG_MDIO_CMD), data);
            m_cmd = data;
            m_phy[pa][ra] = data[15:0];
            wait_mdio_idle();
            data = {2'b01, 2'b10, pa, ra, 18'h0};
            axi_write(16'(REG_MDIO_CMD), data);
            m_cmd = data;
            wait_mdio_idle();
            axi_read(16'(REG_MDIO_DATA), got);
            check_value("mdio_read", 32'(m_phy[pa][ra]), 32'(got[15:0]));
            axi_read(16'(REG_MDIO_CMD), got);
            check_value("mdio_cmd", m_cmd, got);
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/mgmt_regs_pkg.sv
source/mdio_pkg.sv
source/axil_port.sv
source/mgmt_regs.sv
source/mdio_master.sv
source/mac_mgmt_top.sv
testbench/tb_phy_mdio.sv
testbench/mac_mgmt_sva.sv
testbench/tb_mac_mgmt.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_mac_mgmt
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
